// ==== src/rob_macros.svh ====
// reorder buffer sizing constants
`ifndef ROB_MACROS_SVH
`define ROB_MACROS_SVH

// reorder buffer depth, a power of two so the pointers wrap on their own
`define ROB_LEN 8

// architectural register file
`define ARCH_REGS 32

// data word width
`define XLEN 32

// hard-wired zero register, never written
`define ZERO_REG 0

`endif

// ==== src/rob_pkg.sv ====
// reorder buffer types
`include "rob_macros.svh"

package rob_pkg;

    typedef logic [$clog2(`ROB_LEN)-1:0] rob_tag_t;   // entry index
    typedef logic [$clog2(`ROB_LEN):0]   rob_count_t; // occupancy, 0..ROB_LEN
    typedef logic [$clog2(`ARCH_REGS)-1:0] reg_idx_t;
    typedef logic [`XLEN-1:0]            xlen_t;

    // instruction from decode
    typedef struct packed {
        logic     valid;
        reg_idx_t dest_reg_idx;
        reg_idx_t rs1_idx;
        reg_idx_t rs2_idx;
        logic     halt;
        logic     illegal;
        xlen_t    npc;
    } id_packet_t;

    // one completion per cycle from the common data bus
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        logic     has_value;
        xlen_t    value;
        logic     take_branch;    // predicted not taken, so taken means mispredict
    } cdb_packet_t;

    typedef struct packed {
        logic     busy;
        logic     complete;
        logic     mispredict;
        reg_idx_t dest_reg_idx;
        xlen_t    value;
        logic     halt;
        logic     illegal;
        xlen_t    npc;
    } rob_entry_packet_t;

    // commit of the head entry
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        reg_idx_t dest_reg_idx;
        xlen_t    value;
        logic     write_en;       // architectural write allowed
        logic     halt;
        logic     illegal;
        xlen_t    npc;
    } retire_packet_t;

    // resolved source operand
    typedef struct packed {
        logic     ready;
        rob_tag_t tag;            // producer when not ready
        xlen_t    value;
    } operand_t;

endpackage

// ==== src/rob_entry.sv ====
// reorder buffer slot
`timescale 1ns/100ps

module rob_entry (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       clear,      // squash
    input  logic                       write,
    input  rob_pkg::id_packet_t        dispatch,
    input  logic                       complete,
    input  rob_pkg::cdb_packet_t       cdb,
    input  logic                       release_en, // head retiring
    output rob_pkg::rob_entry_packet_t entry
);

    logic              busy;
    logic              done;        // result has arrived
    logic              mispredict;
    rob_pkg::reg_idx_t dest_reg_idx;
    rob_pkg::xlen_t    value;
    logic              halt;
    logic              illegal;
    rob_pkg::xlen_t    npc;

    // slot status
    always_ff @(posedge clock) begin
        if (reset || clear || release_en) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            mispredict <= 1'b0;
        end else if (write) begin
            busy       <= 1'b1;
            done       <= 1'b0;
            mispredict <= 1'b0;
        end else if (complete) begin
            done <= 1'b1;
            if (cdb.take_branch)
                mispredict <= 1'b1; // branch went the other way
        end
    end

    // payload
    always_ff @(posedge clock) begin
        if (write) begin
            dest_reg_idx <= dispatch.dest_reg_idx;
            halt         <= dispatch.halt;
            illegal      <= dispatch.illegal;
            npc          <= dispatch.npc;
            value        <= '0;             // no-result ops retire zero
        end else if (complete && cdb.has_value) begin
            value <= cdb.value;
        end
    end

    assign entry.busy         = busy;
    assign entry.complete     = done;
    assign entry.mispredict   = mispredict;
    assign entry.dest_reg_idx = dest_reg_idx;
    assign entry.value        = value;
    assign entry.halt         = halt;
    assign entry.illegal      = illegal;
    assign entry.npc          = npc;

    // tail pointer must only ever land on a free slot
    write_to_idle: assert property (@(posedge clock) disable iff (reset) write |-> !busy)
        else $error("rob_entry: dispatch into a busy slot");

endmodule

// ==== src/reorder_buffer.sv ====
// reorder buffer
`timescale 1ns/100ps
`include "rob_macros.svh"

module reorder_buffer (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    stall,
    input  rob_pkg::id_packet_t     id_packet,
    input  rob_pkg::cdb_packet_t    cdb_packet,
    input  rob_pkg::rob_tag_t       src1_tag,
    input  rob_pkg::rob_tag_t       src2_tag,
    output rob_pkg::rob_tag_t       dispatch_tag,
    output logic                    rob_full,
    output rob_pkg::retire_packet_t retire_packet,
    output logic                    squash,
    output rob_pkg::xlen_t          src1_value,
    output rob_pkg::xlen_t          src2_value,
    output logic                    src1_complete,
    output logic                    src2_complete
);

    rob_pkg::rob_tag_t          head;
    rob_pkg::rob_tag_t          tail;
    rob_pkg::rob_count_t        count;
    rob_pkg::rob_entry_packet_t entries [`ROB_LEN];
    rob_pkg::rob_entry_packet_t head_entry;

    logic [`ROB_LEN-1:0] write_vec;
    logic [`ROB_LEN-1:0] complete_vec;
    logic [`ROB_LEN-1:0] release_vec;
    logic                dispatch_en;
    logic                complete_en;
    logic                retire;

    assign rob_full     = (count == rob_pkg::rob_count_t'(`ROB_LEN));
    assign dispatch_tag = tail;
    assign head_entry   = entries[head];

    // a squash drops the same-cycle dispatch
    assign dispatch_en = id_packet.valid && !rob_full && !stall && !squash;
    assign complete_en = cdb_packet.valid && entries[cdb_packet.tag].busy && !stall;

    assign retire = head_entry.busy && head_entry.complete && !stall;
    assign squash = retire && head_entry.mispredict;

    // one-hot slot strobes
    always_comb begin
        write_vec    = '0;
        complete_vec = '0;
        release_vec  = '0;
        for (int i = 0; i < `ROB_LEN; i++) begin
            if (dispatch_en && rob_pkg::rob_tag_t'(i) == tail)
                write_vec[i] = 1'b1;
            if (complete_en && rob_pkg::rob_tag_t'(i) == cdb_packet.tag)
                complete_vec[i] = 1'b1;
            if (retire && rob_pkg::rob_tag_t'(i) == head)
                release_vec[i] = 1'b1;
        end
    end

    for (genvar i = 0; i < `ROB_LEN; i++) begin : g_slot
        rob_entry i_entry (
            .clock      (clock),
            .reset      (reset),
            .clear      (squash),
            .write      (write_vec[i]),
            .dispatch   (id_packet),
            .complete   (complete_vec[i]),
            .cdb        (cdb_packet),
            .release_en (release_vec[i]),
            .entry      (entries[i])
        );
    end

    // commit packet, quiet unless retiring
    always_comb begin
        retire_packet = '0;
        if (retire) begin
            retire_packet.valid        = 1'b1;
            retire_packet.tag          = head;
            retire_packet.dest_reg_idx = head_entry.dest_reg_idx;
            retire_packet.value        = head_entry.value;
            retire_packet.halt         = head_entry.halt;
            retire_packet.illegal      = head_entry.illegal;
            retire_packet.npc          = head_entry.npc;
            retire_packet.write_en     = (head_entry.dest_reg_idx !=
                                          rob_pkg::reg_idx_t'(`ZERO_REG))
                                         && !head_entry.halt && !head_entry.illegal;
        end
    end

    // pointers
    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (squash) begin
            // branch itself retires, everything younger is gone
            head  <= head + rob_pkg::rob_tag_t'(1);
            tail  <= head + rob_pkg::rob_tag_t'(1);
            count <= '0;
        end else begin
            if (retire)
                head <= head + rob_pkg::rob_tag_t'(1);
            if (dispatch_en)
                tail <= tail + rob_pkg::rob_tag_t'(1);
            count <= count + rob_pkg::rob_count_t'(dispatch_en)
                           - rob_pkg::rob_count_t'(retire);
        end
    end

    // source lookup for the operand stage
    assign src1_value    = entries[src1_tag].value;
    assign src1_complete = entries[src1_tag].complete;
    assign src2_value    = entries[src2_tag].value;
    assign src2_complete = entries[src2_tag].complete;

    count_bound: assert property (@(posedge clock) disable iff (reset)
        count <= rob_pkg::rob_count_t'(`ROB_LEN))
        else $error("reorder_buffer: occupancy above depth");

    // CDB producers only hold tags of live entries
    cdb_to_busy: assert property (@(posedge clock) disable iff (reset)
        cdb_packet.valid && !stall |-> entries[cdb_packet.tag].busy)
        else $error("reorder_buffer: completion for idle entry %0d", cdb_packet.tag);

endmodule

// ==== src/rename_map.sv ====
// register rename map
`timescale 1ns/100ps
`include "rob_macros.svh"

module rename_map (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    stall,
    input  rob_pkg::id_packet_t     id_packet,
    input  rob_pkg::rob_tag_t       dispatch_tag,
    input  logic                    rob_full,
    input  rob_pkg::retire_packet_t retire_packet,
    input  logic                    squash,
    output logic                    rs1_busy,
    output rob_pkg::rob_tag_t       rs1_tag,
    output logic                    rs2_busy,
    output rob_pkg::rob_tag_t       rs2_tag
);

    logic              busy [`ARCH_REGS];
    rob_pkg::rob_tag_t tags [`ARCH_REGS];   // youngest producer
    logic              rename_en;
    logic              retire_hit;

    assign rename_en = id_packet.valid && !rob_full && !stall && !squash
                       && id_packet.dest_reg_idx != rob_pkg::reg_idx_t'(`ZERO_REG);

    // only the latest producer may release its register
    assign retire_hit = retire_packet.valid
                        && tags[retire_packet.dest_reg_idx] == retire_packet.tag;

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            for (int i = 0; i < `ARCH_REGS; i++)
                busy[i] <= 1'b0;
        end else begin
            if (retire_hit)
                busy[retire_packet.dest_reg_idx] <= 1'b0;
            if (rename_en)
                busy[id_packet.dest_reg_idx] <= 1'b1;   // wins over a retire
        end
    end

    always_ff @(posedge clock) begin
        if (rename_en)
            tags[id_packet.dest_reg_idx] <= dispatch_tag;
    end

    // table as it stood before this cycle's dispatch
    assign rs1_busy = busy[id_packet.rs1_idx];
    assign rs1_tag  = tags[id_packet.rs1_idx];
    assign rs2_busy = busy[id_packet.rs2_idx];
    assign rs2_tag  = tags[id_packet.rs2_idx];

endmodule

// ==== src/operand_fetch.sv ====
// register file and operand resolution
`timescale 1ns/100ps
`include "rob_macros.svh"

module operand_fetch (
    input  logic                    clock,
    input  logic                    reset,
    input  rob_pkg::retire_packet_t retire_packet,
    input  rob_pkg::reg_idx_t       rs1_idx,
    input  rob_pkg::reg_idx_t       rs2_idx,
    input  logic                    rs1_busy,
    input  rob_pkg::rob_tag_t       rs1_tag,
    input  logic                    rs2_busy,
    input  rob_pkg::rob_tag_t       rs2_tag,
    input  rob_pkg::xlen_t          rob1_value,
    input  logic                    rob1_complete,
    input  rob_pkg::xlen_t          rob2_value,
    input  logic                    rob2_complete,
    output rob_pkg::operand_t       rs1_operand,
    output rob_pkg::operand_t       rs2_operand
);

    rob_pkg::xlen_t regs [`ARCH_REGS];
    rob_pkg::xlen_t rf1_value;
    rob_pkg::xlen_t rf2_value;

    // register file, written as the head retires
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REGS; i++)
                regs[i] <= '0;
        end else if (retire_packet.write_en) begin
            regs[retire_packet.dest_reg_idx] <= retire_packet.value;
        end
    end

    assign rf1_value = (rs1_idx == rob_pkg::reg_idx_t'(`ZERO_REG)) ? '0 : regs[rs1_idx];
    assign rf2_value = (rs2_idx == rob_pkg::reg_idx_t'(`ZERO_REG)) ? '0 : regs[rs2_idx];

    // regfile if not renamed, buffer if already done, else wait on tag
    function automatic rob_pkg::operand_t resolve(
        input rob_pkg::xlen_t    rf_value,
        input logic              busy,
        input rob_pkg::rob_tag_t tag,
        input rob_pkg::xlen_t    rob_value,
        input logic              rob_complete
    );
        rob_pkg::operand_t op;
        op = '0;
        if (!busy) begin
            op.ready = 1'b1;
            op.value = rf_value;
        end else if (rob_complete) begin
            op.ready = 1'b1;
            op.value = rob_value;
        end else begin
            op.tag = tag;
        end
        return op;
    endfunction

    assign rs1_operand = resolve(rf1_value, rs1_busy, rs1_tag, rob1_value, rob1_complete);
    assign rs2_operand = resolve(rf2_value, rs2_busy, rs2_tag, rob2_value, rob2_complete);

endmodule

// ==== src/rob_subsystem.sv ====
// in-order commit subsystem
`timescale 1ns/100ps

module rob_subsystem (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    stall,
    input  rob_pkg::id_packet_t     id_packet,
    input  rob_pkg::cdb_packet_t    cdb_packet,
    output logic                    rob_full,
    output rob_pkg::rob_tag_t       dispatch_tag,
    output rob_pkg::retire_packet_t retire_packet,
    output logic                    squash,
    output rob_pkg::operand_t       rs1_operand,
    output rob_pkg::operand_t       rs2_operand
);

    logic              rs1_busy;
    logic              rs2_busy;
    rob_pkg::rob_tag_t rs1_tag;
    rob_pkg::rob_tag_t rs2_tag;
    rob_pkg::xlen_t    rob1_value;
    rob_pkg::xlen_t    rob2_value;
    logic              rob1_complete;
    logic              rob2_complete;

    reorder_buffer i_rob (
        .clock         (clock),
        .reset         (reset),
        .stall         (stall),
        .id_packet     (id_packet),
        .cdb_packet    (cdb_packet),
        .src1_tag      (rs1_tag),
        .src2_tag      (rs2_tag),
        .dispatch_tag  (dispatch_tag),
        .rob_full      (rob_full),
        .retire_packet (retire_packet),
        .squash        (squash),
        .src1_value    (rob1_value),
        .src2_value    (rob2_value),
        .src1_complete (rob1_complete),
        .src2_complete (rob2_complete)
    );

    rename_map i_map (
        .clock         (clock),
        .reset         (reset),
        .stall         (stall),
        .id_packet     (id_packet),
        .dispatch_tag  (dispatch_tag),
        .rob_full      (rob_full),
        .retire_packet (retire_packet),
        .squash        (squash),
        .rs1_busy      (rs1_busy),
        .rs1_tag       (rs1_tag),
        .rs2_busy      (rs2_busy),
        .rs2_tag       (rs2_tag)
    );

    operand_fetch i_operands (
        .clock         (clock),
        .reset         (reset),
        .retire_packet (retire_packet),
        .rs1_idx       (id_packet.rs1_idx),
        .rs2_idx       (id_packet.rs2_idx),
        .rs1_busy      (rs1_busy),
        .rs1_tag       (rs1_tag),
        .rs2_busy      (rs2_busy),
        .rs2_tag       (rs2_tag),
        .rob1_value    (rob1_value),
        .rob1_complete (rob1_complete),
        .rob2_value    (rob2_value),
        .rob2_complete (rob2_complete),
        .rs1_operand   (rs1_operand),
        .rs2_operand   (rs2_operand)
    );

endmodule

// ==== tests/tb_rob_subsystem.sv ====
// reorder buffer subsystem testbench
`timescale 1ns/100ps
`include "rob_macros.svh"

module tb_rob_subsystem;

    localparam int STIM_CYCLES = 700;   // rough length of all five tests

    typedef struct packed {
        logic                    full;
        rob_pkg::rob_tag_t       dtag;
        rob_pkg::retire_packet_t rp;
        logic                    squash;
        rob_pkg::operand_t       op1;
        rob_pkg::operand_t       op2;
    } expect_t;

    logic                    clock;
    logic                    reset;
    logic                    stall;
    rob_pkg::id_packet_t     id_packet;
    rob_pkg::cdb_packet_t    cdb_packet;
    logic                    rob_full;
    rob_pkg::rob_tag_t       dispatch_tag;
    rob_pkg::retire_packet_t retire_packet;
    logic                    squash;
    rob_pkg::operand_t       rs1_operand;
    rob_pkg::operand_t       rs2_operand;

    // reference model state
    logic              m_busy [`ROB_LEN];
    logic              m_done [`ROB_LEN];
    logic              m_misp [`ROB_LEN];
    logic              m_halt [`ROB_LEN];
    logic              m_ill  [`ROB_LEN];
    rob_pkg::reg_idx_t m_dest [`ROB_LEN];
    rob_pkg::xlen_t    m_val  [`ROB_LEN];
    rob_pkg::xlen_t    m_npc  [`ROB_LEN];
    rob_pkg::rob_tag_t m_head;
    rob_pkg::rob_tag_t m_tail;
    int                m_count;
    rob_pkg::xlen_t    m_rf   [`ARCH_REGS];
    logic              m_mbusy [`ARCH_REGS];
    rob_pkg::rob_tag_t m_mtag [`ARCH_REGS];
    logic              m_accepted;

    logic [31:0] lfsr = 32'haae9_0a8a;
    int          errors = 0;
    int          test_errors = 0;
    int          tests = 0;

    rob_subsystem i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return r;
    endfunction

    function automatic rob_pkg::operand_t expected_operand(input rob_pkg::reg_idx_t r);
        rob_pkg::operand_t o;
        o = '0;
        if (!m_mbusy[r]) begin
            o.ready = 1'b1;
            o.value = (r == rob_pkg::reg_idx_t'(`ZERO_REG)) ? '0 : m_rf[r];
        end else if (m_done[m_mtag[r]]) begin
            o.ready = 1'b1;
            o.value = m_val[m_mtag[r]];
        end else begin
            o.tag = m_mtag[r];
        end
        return o;
    endfunction

    // what the outputs must be in this cycle
    function automatic expect_t expected_outputs();
        expect_t e;
        rob_pkg::rob_tag_t h;
        e = '0;
        h = m_head;
        e.full = (m_count == `ROB_LEN);
        e.dtag = m_tail;
        if (m_busy[h] && m_done[h] && !stall) begin
            e.rp.valid        = 1'b1;
            e.rp.tag          = h;
            e.rp.dest_reg_idx = m_dest[h];
            e.rp.value        = m_val[h];
            e.rp.halt         = m_halt[h];
            e.rp.illegal      = m_ill[h];
            e.rp.npc          = m_npc[h];
            e.rp.write_en     = m_dest[h] != 0 && !m_halt[h] && !m_ill[h];
            e.squash          = m_misp[h];
        end
        e.op1 = expected_operand(id_packet.rs1_idx);
        e.op2 = expected_operand(id_packet.rs2_idx);
        return e;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < `ROB_LEN; i++) begin
            m_busy[i] = 0;
            m_done[i] = 0;
            m_misp[i] = 0;
        end
        for (int i = 0; i < `ARCH_REGS; i++) begin
            m_rf[i] = '0;
            m_mbusy[i] = 0;
        end
        m_head = '0;
        m_tail = '0;
        m_count = 0;
        m_accepted = 1;
    endtask

    // advance the model by one clock edge
    task automatic model_step();
        expect_t e;
        rob_pkg::rob_tag_t h;
        rob_pkg::rob_tag_t t;
        logic disp;
        logic comp;
        logic ren;
        e = expected_outputs();
        h = m_head;
        t = cdb_packet.tag;
        disp = id_packet.valid && !e.full && !stall && !e.squash;
        comp = cdb_packet.valid && m_busy[t] && !stall;
        ren  = disp && id_packet.dest_reg_idx != 0;
        m_accepted = disp || !id_packet.valid;
        if (e.rp.write_en)
            m_rf[e.rp.dest_reg_idx] = e.rp.value;
        if (e.squash) begin
            for (int i = 0; i < `ARCH_REGS; i++)
                m_mbusy[i] = 0;
        end else if (e.rp.valid && m_mtag[e.rp.dest_reg_idx] == h) begin
            m_mbusy[e.rp.dest_reg_idx] = 0;
        end
        if (ren) begin
            m_mbusy[id_packet.dest_reg_idx] = 1;    // newer rename wins
            m_mtag[id_packet.dest_reg_idx] = m_tail;
        end
        if (comp) begin
            m_done[t] = 1;
            m_misp[t] = m_misp[t] | cdb_packet.take_branch;
            if (cdb_packet.has_value)
                m_val[t] = cdb_packet.value;
        end
        if (disp) begin
            m_busy[m_tail] = 1;
            m_done[m_tail] = 0;
            m_misp[m_tail] = 0;
            m_dest[m_tail] = id_packet.dest_reg_idx;
            m_halt[m_tail] = id_packet.halt;
            m_ill[m_tail]  = id_packet.illegal;
            m_npc[m_tail]  = id_packet.npc;
            m_val[m_tail]  = '0;
        end
        if (e.squash) begin
            for (int i = 0; i < `ROB_LEN; i++) begin
                m_busy[i] = 0;
                m_done[i] = 0;
                m_misp[i] = 0;
            end
            m_head  = h + 1'b1;
            m_tail  = h + 1'b1;
            m_count = 0;
        end else begin
            if (e.rp.valid) begin
                m_busy[h] = 0;
                m_done[h] = 0;
                m_misp[h] = 0;
                m_head = h + 1'b1;
            end
            if (disp)
                m_tail = m_tail + 1'b1;
            m_count = m_count + int'(disp) - int'(e.rp.valid);
        end
    endtask

    always @(posedge clock) begin
        if (reset)
            model_reset();
        else
            model_step();
    end

    task automatic check_field(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        assert (act === exp)
        else begin
            $display("ERROR %0t ns %s expected %h actual %h", $time, name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    // compare mid-cycle, inputs and outputs settled
    always @(negedge clock) begin : compare
        expect_t e;
        if (!reset) begin
            e = expected_outputs();
            check_field("rob_full", e.full, rob_full);
            check_field("dispatch_tag", e.dtag, dispatch_tag);
            check_field("retire_packet", e.rp, retire_packet);
            check_field("squash", e.squash, squash);
            check_field("rs1_operand", e.op1, rs1_operand);
            check_field("rs2_operand", e.op2, rs2_operand);
        end
    end

    task automatic next_cycle();
        @(posedge clock);
        #10;
    endtask

    function automatic rob_pkg::id_packet_t make_instr(input logic odd);
        rob_pkg::id_packet_t p;
        p.valid        = 1'b1;
        p.dest_reg_idx = rand_bits(5);
        p.rs1_idx      = rand_bits(5);
        p.rs2_idx      = rand_bits(5);
        p.halt         = odd && rand_bits(4) == 0;
        p.illegal      = odd && rand_bits(4) == 0;
        p.npc          = rand_bits(32);
        return p;
    endfunction

    task automatic dispatch(input int dest);
        next_cycle();
        cdb_packet.valid = 0;
        id_packet = make_instr(0);
        if (dest >= 0)
            id_packet.dest_reg_idx = dest;
    endtask

    task automatic complete(input rob_pkg::rob_tag_t tag, input rob_pkg::xlen_t v,
                            input logic branch);
        next_cycle();
        id_packet.valid = 0;
        cdb_packet = '{valid: 1'b1, tag: tag, has_value: 1'b1, value: v, take_branch: branch};
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        next_cycle();
        id_packet.valid = 0;
        cdb_packet.valid = 0;
        stall = 0;
        while (m_count != 0 && n < limit) begin
            next_cycle();
            n++;
        end
        if (m_count != 0) begin
            $display("ERROR buffer still holds %0d entries after %0d cycles", m_count, limit);
            errors++;
            test_errors++;
        end
    endtask

    task automatic read_regs(input int r1, input int r2);
        next_cycle();
        id_packet.valid = 0;
        cdb_packet.valid = 0;
        id_packet.rs1_idx = r1;
        id_packet.rs2_idx = r2;
        @(negedge clock);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, test_errors);
        test_errors = 0;
    endtask

    initial begin
        rob_pkg::rob_tag_t base;
        rob_pkg::rob_tag_t order[$];
        rob_pkg::xlen_t    va;
        rob_pkg::xlen_t    vc;
        int                k;
        reset = 1;
        stall = 0;
        id_packet = '0;
        cdb_packet = '0;
        repeat (4) @(posedge clock);
        #10 reset = 0;

        // in-order retirement, completions in scrambled order
        base = m_head;
        for (int i = 0; i < `ROB_LEN; i++) begin
            dispatch(i == 3 ? 0 : -1);   // one write aimed at the zero register
            order.push_back(base + i);
        end
        while (order.size() > 0) begin
            k = rand_bits(3) % order.size();
            complete(order[k], rand_bits(32), 0);
            order.delete(k);
        end
        wait_drained(20);
        read_regs(0, 0);
        check_field("rs1_operand.value", 0, rs1_operand.value);
        end_test("in-order retirement");

        // full buffer, then stall freezes everything
        base = m_head;
        for (int i = 0; i < `ROB_LEN + 2; i++)
            dispatch(-1);
        @(negedge clock);
        check_field("rob_full", 1, rob_full);
        complete(base, rand_bits(32), 0);
        next_cycle();
        stall = 1;
        id_packet = make_instr(0);
        cdb_packet = '{valid: 1'b1, tag: base + 1'b1, has_value: 1'b1, value: 32'h1234_5678,
                       take_branch: 1'b0};
        repeat (4) next_cycle();
        @(negedge clock);
        check_field("rob_full", 1, rob_full);       // completed head held back
        next_cycle();
        stall = 0;
        id_packet.valid = 0;
        cdb_packet.valid = 0;
        @(negedge clock);
        check_field("retire_packet.valid", 1, retire_packet.valid);
        check_field("retire_packet.tag", base, retire_packet.tag);
        next_cycle();
        @(negedge clock);
        check_field("retire_packet.valid", 0, retire_packet.valid);
        next_cycle();
        stall = 1;
        id_packet = make_instr(0);
        repeat (2) next_cycle();
        @(negedge clock);
        check_field("dispatch_tag", base, dispatch_tag);
        check_field("rob_full", 0, rob_full);
        next_cycle();
        stall = 0;
        id_packet.valid = 0;
        for (int i = 1; i < `ROB_LEN; i++)
            complete(base + i, rand_bits(32), 0);
        wait_drained(20);
        end_test("full and stall");

        // mispredicted branch in the middle
        base = m_head;
        for (int i = 0; i < 5; i++)
            dispatch(-1);
        for (int i = 4; i >= 0; i--)
            complete(base + i, rand_bits(32), i == 2);
        next_cycle();
        cdb_packet.valid = 0;
        k = 0;
        @(negedge clock);
        while (!squash && k < 20) begin
            @(negedge clock);
            k++;
        end
        if (!squash) begin
            $display("ERROR squash never came for the mispredicted branch");
            errors++;
            test_errors++;
        end
        check_field("retire_packet.tag", base + 2'd2, retire_packet.tag);
        for (int i = 0; i < `ARCH_REGS; i++) begin
            read_regs(i, `ARCH_REGS - 1 - i);
            check_field("rs1_operand.ready", 1, rs1_operand.ready);
        end
        dispatch(-1);
        @(negedge clock);
        check_field("dispatch_tag", base + 2'd3, dispatch_tag);
        complete(base + 2'd3, rand_bits(32), 0);
        wait_drained(20);
        end_test("squash");

        // register file, pending tag, buffer value, re-rename
        base = m_head;
        va = rand_bits(32);
        vc = rand_bits(32);
        dispatch(5);
        complete(base, va, 0);
        wait_drained(10);
        dispatch(6);
        dispatch(7);
        complete(base + 2'd2, vc, 0);
        read_regs(5, 6);
        check_field("rs1_operand.value", va, rs1_operand.value);
        check_field("rs2_operand.tag", base + 2'd1, rs2_operand.tag);
        check_field("rs2_operand.ready", 0, rs2_operand.ready);
        read_regs(7, 6);
        check_field("rs1_operand.value", vc, rs1_operand.value);
        dispatch(6);
        complete(base + 2'd1, rand_bits(32), 0);
        repeat (3) read_regs(6, 7);
        check_field("rs1_operand.tag", base + 2'd3, rs1_operand.tag);
        check_field("rs1_operand.ready", 0, rs1_operand.ready);
        complete(base + 2'd3, vc + 1, 0);
        wait_drained(10);
        read_regs(6, 6);
        check_field("rs1_operand.value", vc + 1, rs1_operand.value);
        end_test("operand resolution");

        // random mix of dispatch, completion, branch and stall
        for (int c = 0; c < 400; c++) begin
            next_cycle();
            stall = rand_bits(3) == 0;
            if (m_accepted)
                id_packet = make_instr(1);
            if (m_accepted && rand_bits(2) == 0)
                id_packet.valid = 0;
            cdb_packet.valid = 0;
            k = rand_bits(3);
            for (int i = 0; i < `ROB_LEN; i++) begin
                if (!cdb_packet.valid && m_busy[(k + i) % `ROB_LEN]
                    && !m_done[(k + i) % `ROB_LEN]) begin
                    cdb_packet.tag = (k + i) % `ROB_LEN;
                    cdb_packet.valid = 1;
                end
            end
            cdb_packet.valid = cdb_packet.valid && rand_bits(2) != 0;
            cdb_packet.has_value = rand_bits(3) != 0;
            cdb_packet.value = rand_bits(32);
            cdb_packet.take_branch = rand_bits(4) == 0;
        end
        // finish the leftovers one head at a time
        for (int i = 0; i < 3 * `ROB_LEN; i++) begin
            next_cycle();
            stall = 0;
            id_packet.valid = 0;
            cdb_packet.valid = 0;
            if (m_busy[m_head] && !m_done[m_head]) begin
                cdb_packet.tag = m_head;
                cdb_packet.has_value = 1'b1;
                cdb_packet.value = rand_bits(32);
                cdb_packet.take_branch = 1'b0;
                cdb_packet.valid = 1'b1;
            end
        end
        wait_drained(30);
        end_test("random mix");

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        #((STIM_CYCLES + 200) * 100);
        $display("ERROR run did not finish within %0d cycles", STIM_CYCLES + 200);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== rob_subsystem.f ====
+incdir+src
src/rob_pkg.sv
src/rob_entry.sv
src/reorder_buffer.sv
src/rename_map.sv
src/operand_fetch.sv
src/rob_subsystem.sv
tests/tb_rob_subsystem.sv
